//--- src/dtm_pkg.sv
// Shared DTM definitions; DMI address width and FIFO depth are fixed, with no per-instance override
`default_nettype none

package dtm_pkg;

  // --------------------------------------------------------------------
  // Sizes and constants
  // --------------------------------------------------------------------
  localparam int unsigned IR_LEN       = 5;
  // Version 1, part 0x0000, manufacturer 0x6D9, bit 0 set as JTAG requires
  localparam logic [31:0] IDCODE_VALUE = 32'h1000_0DB3;
  localparam int unsigned DMI_ABITS    = 7;
  // Address, 32 data bits and 2 op bits
  localparam int unsigned DMI_WIDTH    = DMI_ABITS + 32 + 2;
  localparam logic [3:0]  DTM_VERSION  = 4'd1;
  localparam int unsigned FIFO_DEPTH   = 4;
  localparam int unsigned FIFO_AW      = $clog2(FIFO_DEPTH);
  localparam int unsigned DM_NUM_REGS  = 16;
  localparam int unsigned DM_IDX_W     = $clog2(DM_NUM_REGS);
  // Fixed pattern seen on TDO during Shift-IR, LSBs are 01
  localparam logic [IR_LEN-1:0] IR_CAPTURE = 5'b00101;
  // Response codes share the op bits of a DMI scan
  localparam logic [1:0]  DMI_RESP_SUCCESS = 2'd0;
  localparam logic [1:0]  DMI_RESP_BUSY    = 2'd3;

  // --------------------------------------------------------------------
  // Enums
  // --------------------------------------------------------------------
  typedef enum logic [3:0] {
    TAP_RESET, TAP_IDLE, TAP_SELECT_DR, TAP_CAPTURE_DR,
    TAP_SHIFT_DR, TAP_EXIT1_DR, TAP_PAUSE_DR, TAP_EXIT2_DR,
    TAP_UPDATE_DR, TAP_SELECT_IR, TAP_CAPTURE_IR, TAP_SHIFT_IR,
    TAP_EXIT1_IR, TAP_PAUSE_IR, TAP_EXIT2_IR, TAP_UPDATE_IR
  } tap_state_e;

  typedef enum logic [IR_LEN-1:0] {
    BYPASS0   = 5'h00,
    IDCODE    = 5'h01,
    DTMCS     = 5'h10,
    DMIACCESS = 5'h11,
    BYPASS1   = 5'h1F
  } ir_e;

  // Op code 3 is reserved and never pushed
  typedef enum logic [1:0] {
    NOP   = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } dmi_op_e;

  // --------------------------------------------------------------------
  // Bundles
  // --------------------------------------------------------------------
  // Field order matches the DMI scan layout, address in the MSBs
  typedef struct packed {
    logic [DMI_ABITS-1:0] addr;
    logic [31:0]          data;
    dmi_op_e              op;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } dmi_resp_t;

  // TAP strobes toward the scan registers, valid for one TCK cycle
  typedef struct packed {
    logic capture_dr;
    logic shift_dr;
    logic update_dr;
    logic test_logic_reset;
    logic dtmcs_sel;
    logic dmi_sel;
  } tap_ctrl_t;

endpackage

`default_nettype wire

//--- src/dtm_jtag_tap.sv
// JTAG TAP, single TCK domain; TDO uses a plain negedge flop, no DFT clock inverter or test mode
`default_nettype none
`timescale 1ns/1ps

module dtm_jtag_tap (
  input  logic               tck_i,
  input  logic               trst_ni,
  input  logic               tms_i,
  input  logic               td_i,
  // LSB of the selected DTMCS or DMI register
  input  logic               scan_tdo_i,
  output dtm_pkg::tap_ctrl_t tap_ctrl_o,
  output logic               td_o,
  output logic               tdo_oe_o
);

  import dtm_pkg::*;

  tap_state_e        state_q, state_d;
  logic              capture_ir, shift_ir, update_ir;
  logic              capture_dr, shift_dr, update_dr;
  logic              tlr;
  logic [IR_LEN-1:0] ir_sr_q;
  ir_e               ir_q;
  logic [31:0]       idcode_q;
  logic              bypass_q;
  logic              idcode_sel, bypass_sel, dtmcs_sel, dmi_sel;
  logic              tdo_mux;

  // --------------------------------------------------------------------
  // TAP state machine
  // --------------------------------------------------------------------
  always_comb begin
    unique case (state_q)
      TAP_RESET:      state_d = tms_i ? TAP_RESET     : TAP_IDLE;
      TAP_IDLE:       state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
      // DR column
      TAP_SELECT_DR:  state_d = tms_i ? TAP_SELECT_IR : TAP_CAPTURE_DR;
      TAP_CAPTURE_DR: state_d = tms_i ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
      TAP_SHIFT_DR:   state_d = tms_i ? TAP_EXIT1_DR  : TAP_SHIFT_DR;
      TAP_EXIT1_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_PAUSE_DR;
      TAP_PAUSE_DR:   state_d = tms_i ? TAP_EXIT2_DR  : TAP_PAUSE_DR;
      TAP_EXIT2_DR:   state_d = tms_i ? TAP_UPDATE_DR : TAP_SHIFT_DR;
      TAP_UPDATE_DR:  state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
      // IR column
      TAP_SELECT_IR:  state_d = tms_i ? TAP_RESET     : TAP_CAPTURE_IR;
      TAP_CAPTURE_IR: state_d = tms_i ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
      TAP_SHIFT_IR:   state_d = tms_i ? TAP_EXIT1_IR  : TAP_SHIFT_IR;
      TAP_EXIT1_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_PAUSE_IR;
      TAP_PAUSE_IR:   state_d = tms_i ? TAP_EXIT2_IR  : TAP_PAUSE_IR;
      TAP_EXIT2_IR:   state_d = tms_i ? TAP_UPDATE_IR : TAP_SHIFT_IR;
      TAP_UPDATE_IR:  state_d = tms_i ? TAP_SELECT_DR : TAP_IDLE;
      default:        state_d = TAP_RESET;
    endcase
  end

  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      state_q <= TAP_RESET;
    end else begin
      state_q <= state_d;
    end
  end

  // Strobes act at the rising edge that ends their state
  assign tlr        = (state_q == TAP_RESET);
  assign capture_ir = (state_q == TAP_CAPTURE_IR);
  assign shift_ir   = (state_q == TAP_SHIFT_IR);
  assign update_ir  = (state_q == TAP_UPDATE_IR);
  assign capture_dr = (state_q == TAP_CAPTURE_DR);
  assign shift_dr   = (state_q == TAP_SHIFT_DR);
  assign update_dr  = (state_q == TAP_UPDATE_DR);

  // --------------------------------------------------------------------
  // Instruction register
  // --------------------------------------------------------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      ir_sr_q <= '0;
      ir_q    <= IDCODE;
    end else if (tlr) begin
      ir_sr_q <= '0;
      ir_q    <= IDCODE;
    end else begin
      if (capture_ir) begin
        ir_sr_q <= IR_CAPTURE;
      end else if (shift_ir) begin
        // TDI enters at the MSB, LSB leaves first
        ir_sr_q <= {td_i, ir_sr_q[IR_LEN-1:1]};
      end
      // Unlisted codes are kept and decode to BYPASS below
      if (update_ir) begin
        ir_q <= ir_e'(ir_sr_q);
      end
    end
  end

  // Data register select
  always_comb begin
    idcode_sel = 1'b0;
    bypass_sel = 1'b0;
    dtmcs_sel  = 1'b0;
    dmi_sel    = 1'b0;
    unique case (ir_q)
      IDCODE:    idcode_sel = 1'b1;
      DTMCS:     dtmcs_sel  = 1'b1;
      DMIACCESS: dmi_sel    = 1'b1;
      // BYPASS0, BYPASS1 and any unknown code
      default:   bypass_sel = 1'b1;
    endcase
  end

  // --------------------------------------------------------------------
  // IDCODE and BYPASS data registers
  // --------------------------------------------------------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      idcode_q <= IDCODE_VALUE;
      bypass_q <= 1'b0;
    end else if (tlr) begin
      idcode_q <= IDCODE_VALUE;
      bypass_q <= 1'b0;
    end else begin
      if (capture_dr && idcode_sel) begin
        idcode_q <= IDCODE_VALUE;
      end else if (shift_dr && idcode_sel) begin
        idcode_q <= {td_i, idcode_q[31:1]};
      end
      // One-bit path, captures 0 so the first bit out is 0
      if (capture_dr && bypass_sel) begin
        bypass_q <= 1'b0;
      end else if (shift_dr && bypass_sel) begin
        bypass_q <= td_i;
      end
    end
  end

  // --------------------------------------------------------------------
  // TDO
  // --------------------------------------------------------------------
  always_comb begin
    if (shift_ir) begin
      tdo_mux = ir_sr_q[0];
    end else if (idcode_sel) begin
      tdo_mux = idcode_q[0];
    end else if (dtmcs_sel || dmi_sel) begin
      tdo_mux = scan_tdo_i;
    end else begin
      tdo_mux = bypass_q;
    end
  end

  // Falling edge, so the probe samples stable data on the next rise
  always_ff @(negedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      td_o     <= 1'b0;
      tdo_oe_o <= 1'b0;
    end else begin
      td_o     <= tdo_mux;
      tdo_oe_o <= shift_ir | shift_dr;
    end
  end

  // Control bundle toward the scan registers
  always_comb begin
    tap_ctrl_o.capture_dr       = capture_dr;
    tap_ctrl_o.shift_dr         = shift_dr;
    tap_ctrl_o.update_dr        = update_dr;
    tap_ctrl_o.test_logic_reset = tlr;
    tap_ctrl_o.dtmcs_sel        = dtmcs_sel;
    tap_ctrl_o.dmi_sel          = dmi_sel;
  end

endmodule

`default_nettype wire

//--- src/dtm_dmi_scan.sv
// DTMCS and DMI scan registers; dmihardreset is not implemented and reads 0, no idle cycles needed
`default_nettype none
`timescale 1ns/1ps

module dtm_dmi_scan (
  input  logic               tck_i,
  input  logic               trst_ni,
  input  logic               td_i,
  input  dtm_pkg::tap_ctrl_t tap_ctrl_i,
  output logic               scan_tdo_o,
  // Request side, toward the FIFO
  input  logic               full_i,
  output logic               req_push_o,
  output dtm_pkg::dmi_req_t  req_o,
  // Response side, from the register bank
  input  logic               resp_valid_i,
  input  dtm_pkg::dmi_resp_t resp_i
);

  import dtm_pkg::*;

  logic [31:0]          dtmcs_sr_q;
  logic [DMI_WIDTH-1:0] dmi_sr_q;
  logic [DMI_ABITS-1:0] last_addr_q;
  dmi_resp_t            resp_q;
  logic                 sticky_q;
  logic [31:0]          dtmcs_capture;
  logic [1:0]           resp_code;
  dmi_op_e              scan_op;
  logic                 dmi_update;
  logic                 dmi_reset;

  // --------------------------------------------------------------------
  // Decode
  // --------------------------------------------------------------------
  assign scan_op = dmi_op_e'(dmi_sr_q[1:0]);

  // NOP and the reserved op leave the FIFO alone
  assign dmi_update = tap_ctrl_i.update_dr & tap_ctrl_i.dmi_sel &
                      ((scan_op == READ) | (scan_op == WRITE));
  assign req_push_o = dmi_update & ~full_i;

  assign req_o.addr = dmi_sr_q[DMI_WIDTH-1 -: DMI_ABITS];
  assign req_o.data = dmi_sr_q[DMI_WIDTH-DMI_ABITS-1:2];
  assign req_o.op   = scan_op;

  // dmireset is bit 16 of the value shifted in
  assign dmi_reset = tap_ctrl_i.update_dr & tap_ctrl_i.dtmcs_sel & dtmcs_sr_q[16];

  // dmistat mirrors the sticky flag, 0 or 3
  assign dtmcs_capture = {14'd0, 1'b0, 1'b0, 1'b0, 3'd1, {2{sticky_q}},
                          6'(DMI_ABITS), DTM_VERSION};

  assign resp_code = sticky_q ? DMI_RESP_BUSY : resp_q.resp;

  assign scan_tdo_o = tap_ctrl_i.dtmcs_sel ? dtmcs_sr_q[0] : dmi_sr_q[0];

  // --------------------------------------------------------------------
  // Shift registers
  // --------------------------------------------------------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      dtmcs_sr_q <= '0;
      dmi_sr_q   <= '0;
    end else begin
      if (tap_ctrl_i.dtmcs_sel) begin
        if (tap_ctrl_i.capture_dr) begin
          dtmcs_sr_q <= dtmcs_capture;
        end else if (tap_ctrl_i.shift_dr) begin
          dtmcs_sr_q <= {td_i, dtmcs_sr_q[31:1]};
        end
      end
      if (tap_ctrl_i.dmi_sel) begin
        // Capture shows the previous access and its result
        if (tap_ctrl_i.capture_dr) begin
          dmi_sr_q <= {last_addr_q, resp_q.data, resp_code};
        end else if (tap_ctrl_i.shift_dr) begin
          dmi_sr_q <= {td_i, dmi_sr_q[DMI_WIDTH-1:1]};
        end
      end
    end
  end

  // --------------------------------------------------------------------
  // Response holding and sticky busy
  // --------------------------------------------------------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      last_addr_q <= '0;
      resp_q      <= '0;
    end else begin
      if (dmi_update) begin
        last_addr_q <= req_o.addr;
      end
      if (resp_valid_i) begin
        resp_q <= resp_i;
      end
    end
  end

  // Overflow sets, dmireset or Test-Logic-Reset clears
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      sticky_q <= 1'b0;
    end else if (tap_ctrl_i.test_logic_reset || dmi_reset) begin
      sticky_q <= 1'b0;
    end else if (dmi_update && full_i) begin
      sticky_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/dmi_req_fifo.sv
// DMI request FIFO; a push while full or a pop while empty is dropped, depth must be a power of two
`default_nettype none
`timescale 1ns/1ps

module dmi_req_fifo (
  input  logic              tck_i,
  input  logic              trst_ni,
  input  logic              clear_i,
  input  logic              push_i,
  input  dtm_pkg::dmi_req_t req_i,
  input  logic              pop_i,
  output dtm_pkg::dmi_req_t req_o,
  output logic              empty_o,
  output logic              full_o
);

  import dtm_pkg::*;

  dmi_req_t           mem_q [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr_q, rd_ptr_q;
  logic [FIFO_AW:0]   count_q;
  logic               do_push, do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (FIFO_AW+1)'(FIFO_DEPTH));
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head entry is visible without a pop
  assign req_o = mem_q[rd_ptr_q];

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      unique case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Storage
  always_ff @(posedge tck_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

endmodule

`default_nettype wire

//--- src/dm_reg_bank.sv
// Debug-module stand-in with 16 plain registers; no abstract commands, hart control or bus access
`default_nettype none
`timescale 1ns/1ps

module dm_reg_bank (
  input  logic               tck_i,
  input  logic               trst_ni,
  input  logic               halt_i,
  input  logic               empty_i,
  input  dtm_pkg::dmi_req_t  req_i,
  output logic               pop_o,
  output logic               resp_valid_o,
  output dtm_pkg::dmi_resp_t resp_o
);

  import dtm_pkg::*;

  logic [31:0]         regs_q [DM_NUM_REGS];
  logic                in_range;
  logic [DM_IDX_W-1:0] idx;
  logic [31:0]         rdata;

  // One entry per cycle unless held off
  assign pop_o = ~empty_i & ~halt_i;

  // Addresses above the bank read 0
  assign in_range = (req_i.addr < DMI_ABITS'(DM_NUM_REGS));
  assign idx      = req_i.addr[DM_IDX_W-1:0];
  assign rdata    = in_range ? regs_q[idx] : '0;

  // --------------------------------------------------------------------
  // Register file
  // --------------------------------------------------------------------
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      for (int i = 0; i < DM_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (pop_o && (req_i.op == WRITE) && in_range) begin
      regs_q[idx] <= req_i.data;
    end
  end

  // --------------------------------------------------------------------
  // Response
  // --------------------------------------------------------------------
  // Valid follows the pop by exactly one cycle
  always_ff @(posedge tck_i, negedge trst_ni) begin
    if (!trst_ni) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= pop_o;
    end
  end

  // A write returns the old contents; every access succeeds
  always_ff @(posedge tck_i) begin
    if (pop_o) begin
      resp_o.data <= rdata;
      resp_o.resp <= DMI_RESP_SUCCESS;
    end
  end

endmodule

`default_nettype wire

//--- src/dtm_top.sv
// DTM top; single TCK domain, the register bank stands in for a real debug module
`default_nettype none
`timescale 1ns/1ps

module dtm_top (
  input  logic tck_i,
  input  logic trst_ni,
  input  logic tms_i,
  input  logic td_i,
  // Level that stalls the register bank
  input  logic dm_halt_i,
  output logic td_o,
  output logic tdo_oe_o
);

  import dtm_pkg::*;

  tap_ctrl_t tap_ctrl;
  logic      scan_tdo;
  logic      req_push;
  dmi_req_t  scan_req;
  dmi_req_t  fifo_req;
  logic      full;
  logic      empty;
  logic      pop;
  logic      resp_valid;
  dmi_resp_t resp;

  // --------------------------------------------------------------------
  // Producer, TAP and scan registers
  // --------------------------------------------------------------------
  dtm_jtag_tap u_tap (
    .tck_i      (tck_i),
    .trst_ni    (trst_ni),
    .tms_i      (tms_i),
    .td_i       (td_i),
    .scan_tdo_i (scan_tdo),
    .tap_ctrl_o (tap_ctrl),
    .td_o       (td_o),
    .tdo_oe_o   (tdo_oe_o)
  );

  dtm_dmi_scan u_scan (
    .tck_i        (tck_i),
    .trst_ni      (trst_ni),
    .td_i         (td_i),
    .tap_ctrl_i   (tap_ctrl),
    .scan_tdo_o   (scan_tdo),
    .full_i       (full),
    .req_push_o   (req_push),
    .req_o        (scan_req),
    .resp_valid_i (resp_valid),
    .resp_i       (resp)
  );

  // --------------------------------------------------------------------
  // Buffer and consumer
  // --------------------------------------------------------------------
  // Test-Logic-Reset flushes pending requests
  dmi_req_fifo u_fifo (
    .tck_i   (tck_i),
    .trst_ni (trst_ni),
    .clear_i (tap_ctrl.test_logic_reset),
    .push_i  (req_push),
    .req_i   (scan_req),
    .pop_i   (pop),
    .req_o   (fifo_req),
    .empty_o (empty),
    .full_o  (full)
  );

  dm_reg_bank u_bank (
    .tck_i        (tck_i),
    .trst_ni      (trst_ni),
    .halt_i       (dm_halt_i),
    .empty_i      (empty),
    .req_i        (fifo_req),
    .pop_o        (pop),
    .resp_valid_o (resp_valid),
    .resp_o       (resp)
  );

endmodule

`default_nettype wire

//--- testbench/dtm_top_sva.sv
// Assertions bound into dtm_top; rely on its internal net names and on u_tap
`default_nettype none
`timescale 1ns/1ps

module dtm_top_sva (
  input logic                tck_i,
  input logic                trst_ni,
  input logic                req_push_i,
  input logic                full_i,
  input logic                pop_i,
  input logic                resp_valid_i,
  input logic                tdo_oe_i,
  input dtm_pkg::tap_state_e tap_state_i
);

  import dtm_pkg::*;

  // Number of assertion failures
  int unsigned fail_cnt = 0;

  // --------------------------------------------------------------------
  // FIFO side
  // --------------------------------------------------------------------
  // Overflowing request goes to sticky busy, never to the FIFO
  a_no_push_full: assert property (@(posedge tck_i) disable iff (!trst_ni)
    req_push_i |-> !full_i)
    else begin
      fail_cnt++;
      $error("request pushed while FIFO full");
    end

  // --------------------------------------------------------------------
  // Bank side
  // --------------------------------------------------------------------
  a_pop_resp: assert property (@(posedge tck_i) disable iff (!trst_ni)
    pop_i |=> resp_valid_i)
    else begin
      fail_cnt++;
      $error("no response one cycle after pop");
    end

  a_resp_pop: assert property (@(posedge tck_i) disable iff (!trst_ni)
    resp_valid_i |-> $past(pop_i))
    else begin
      fail_cnt++;
      $error("response without pop in the cycle before");
    end

  // --------------------------------------------------------------------
  // TDO enable
  // --------------------------------------------------------------------
  // Enable set on the fall inside a shift state, so the state is still there at the rise
  a_oe_shift: assert property (@(posedge tck_i) disable iff (!trst_ni)
    tdo_oe_i |-> (tap_state_i == TAP_SHIFT_DR || tap_state_i == TAP_SHIFT_IR))
    else begin
      fail_cnt++;
      $error("tdo_oe_o high outside a shift state");
    end

endmodule

bind dtm_top dtm_top_sva u_sva (
  .tck_i        (tck_i),
  .trst_ni      (trst_ni),
  .req_push_i   (req_push),
  .full_i       (full),
  .pop_i        (pop),
  .resp_valid_i (resp_valid),
  .tdo_oe_i     (tdo_oe_o),
  .tap_state_i  (u_tap.state_q)
);

`default_nettype wire

//--- testbench/tb_dtm_top.sv
// DTM testbench; bit-bangs JTAG at 4 ns TCK and expects the bound SVA instance u_sva in u_dut
`default_nettype none
`timescale 1ns/1ps

module tb_dtm_top;

  import dtm_pkg::*;

  localparam int unsigned RESET_CYCLES = 16;
  localparam int unsigned DRAIN_LIMIT  = 64;
  localparam logic [1:0]  RESP_OK      = 2'd0;
  localparam logic [1:0]  RESP_BUSY    = 2'd3;

  logic        tck_i;
  logic        trst_ni;
  logic        tms_i;
  logic        td_i;
  logic        dm_halt_i;
  logic        td_o;
  logic        tdo_oe_o;

  int unsigned checks;
  int unsigned errors;
  int unsigned timeouts;
  int unsigned sva_fails;
  logic [31:0] lcg_state;
  // Expected contents of the register bank
  logic [31:0] shadow [16];
  logic [63:0] dout;
  logic [40:0] cap;
  logic [4:0]  ir_out;
  logic [4:0]  code;
  logic [6:0]  addr;
  logic [31:0] data;
  logic [31:0] rnd;

  dtm_top u_dut (
    .tck_i     (tck_i),
    .trst_ni   (trst_ni),
    .tms_i     (tms_i),
    .td_i      (td_i),
    .dm_halt_i (dm_halt_i),
    .td_o      (td_o),
    .tdo_oe_o  (tdo_oe_o)
  );

  always #2 tck_i = ~tck_i;

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // DTMCS layout: idle, dmistat, abits, version, upper fields zero
  function automatic logic [31:0] dtmcs_expect(input logic [1:0] dmistat);
    return {17'd0, 3'd1, dmistat, 6'd7, 4'd1};
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("error @ %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // One TCK cycle, inputs on the fall and TDO taken on the rise
  task automatic tck_step(input logic tms, input logic tdi, output logic tdo);
    @(negedge tck_i);
    tms_i = tms;
    td_i  = tdi;
    @(posedge tck_i);
    tdo = td_o;
  endtask

  // Five TMS ones reach Test-Logic-Reset from any state
  task automatic tap_reset();
    logic b;
    for (int i = 0; i < 5; i++) begin
      tck_step(1'b1, 1'b0, b);
    end
  endtask

  // Idle to Idle through Shift-IR
  task automatic ir_scan(input logic [4:0] ir, output logic [4:0] out);
    logic b;
    tck_step(1'b1, 1'b0, b);
    tck_step(1'b1, 1'b0, b);
    tck_step(1'b0, 1'b0, b);
    tck_step(1'b0, 1'b0, b);
    for (int i = 0; i < IR_LEN; i++) begin
      tck_step(i == IR_LEN - 1, ir[i], b);
      out[i] = b;
    end
    tck_step(1'b1, 1'b0, b);
    tck_step(1'b0, 1'b0, b);
  endtask

  // Idle to Idle through Shift-DR, n bits LSB first
  task automatic dr_scan(input int n, input logic [63:0] din, output logic [63:0] out);
    logic b;
    logic oe_all;
    out    = '0;
    oe_all = 1'b1;
    tck_step(1'b1, 1'b0, b);
    tck_step(1'b0, 1'b0, b);
    tck_step(1'b0, 1'b0, b);
    for (int i = 0; i < n; i++) begin
      tck_step(i == n - 1, din[i], b);
      out[i] = b;
      oe_all &= tdo_oe_o;
    end
    // Update-DR, then back to Idle
    tck_step(1'b1, 1'b0, b);
    tck_step(1'b0, 1'b0, b);
    check_value(64'(oe_all), 64'd1, "tdo_oe_o through Shift-DR");
  endtask

  task automatic dmi_access(input logic [6:0] a, input logic [31:0] d, input logic [1:0] op,
                            output logic [40:0] captured);
    logic [63:0] o;
    dr_scan(41, 64'({a, d, op}), o);
    captured = o[40:0];
  endtask

  // Read, then a NOP scan to see the read result
  task automatic dmi_read_check(input logic [6:0] a, input logic [31:0] exp, input string what);
    logic [40:0] c;
    dmi_access(a, 32'd0, READ, c);
    dmi_access(7'd0, 32'd0, NOP, c);
    check_value(64'(c[40:34]), 64'(a), {what, " address"});
    check_value(64'(c[33:2]), 64'(exp), {what, " data"});
    check_value(64'(c[1:0]), 64'(RESP_OK), {what, " resp"});
  endtask

  task automatic wait_fifo_drain();
    int unsigned n;
    n = 0;
    while (!u_dut.empty && n < DRAIN_LIMIT) begin
      @(negedge tck_i);
      n++;
    end
    if (!u_dut.empty) begin
      timeouts++;
      $display("timeout: request FIFO still holds entries after %0d TCK cycles", DRAIN_LIMIT);
    end
  endtask

  // --------------------------------------------------------------------
  // Scenarios
  // --------------------------------------------------------------------
  initial begin
    tck_i     = 1'b0;
    trst_ni   = 1'b0;
    tms_i     = 1'b1;
    td_i      = 1'b0;
    dm_halt_i = 1'b0;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    lcg_state = 32'h8ea6_f1b8;
    for (int i = 0; i < 16; i++) begin
      shadow[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge tck_i);
    @(negedge tck_i);
    trst_ni = 1'b1;

    // IDCODE is the default DR after reset
    tck_step(1'b0, 1'b0, dout[0]);
    dr_scan(32, 64'd0, dout);
    check_value(dout, 64'(IDCODE_VALUE), "IDCODE after reset");

    // Bypass path for both bypass codes and one unlisted code
    for (int k = 0; k < 3; k++) begin
      code = (k == 0) ? 5'h00 : ((k == 1) ? 5'h1F : 5'h0A);
      ir_scan(code, ir_out);
      check_value(64'(ir_out), 64'(5'b00101), "IR capture pattern");
      rnd = lcg_next();
      dr_scan(8, 64'(rnd[7:0]), dout);
      check_value(dout, 64'({rnd[6:0], 1'b0}), "bypass one-bit delay");
    end

    // DTMCS fields
    ir_scan(DTMCS, ir_out);
    dr_scan(32, 64'd0, dout);
    check_value(dout, 64'(dtmcs_expect(2'd0)), "DTMCS after reset");

    // Writes and reads at random addresses inside the bank
    ir_scan(DMIACCESS, ir_out);
    for (int k = 0; k < 6; k++) begin
      rnd  = lcg_next();
      addr = {3'b000, rnd[19:16]};
      data = lcg_next();
      dmi_access(addr, data, WRITE, cap);
      shadow[addr[3:0]] = data;
      dmi_read_check(addr, shadow[addr[3:0]], "DMI read back");
    end
    // Outside the bank writes vanish
    dmi_access(7'h40, lcg_next(), WRITE, cap);
    dmi_read_check(7'h40, 32'd0, "DMI read outside bank");

    // Overflow with the bank held off
    @(negedge tck_i);
    dm_halt_i = 1'b1;
    for (int k = 0; k < 5; k++) begin
      addr = 7'(8 + k);
      data = lcg_next();
      dmi_access(addr, data, WRITE, cap);
      if (k < FIFO_DEPTH) begin
        shadow[addr[3:0]] = data;
      end
    end
    dmi_access(7'd0, 32'd0, NOP, cap);
    check_value(64'(cap[1:0]), 64'(RESP_BUSY), "DMI resp after overflow");
    ir_scan(DTMCS, ir_out);
    // Bit 16 is dmireset
    dr_scan(32, 64'h1_0000, dout);
    check_value(dout, 64'(dtmcs_expect(2'd3)), "DTMCS after overflow");
    dr_scan(32, 64'd0, dout);
    check_value(dout, 64'(dtmcs_expect(2'd0)), "DTMCS after dmireset");
    @(negedge tck_i);
    dm_halt_i = 1'b0;
    wait_fifo_drain();
    ir_scan(DMIACCESS, ir_out);
    for (int k = 0; k < 5; k++) begin
      addr = 7'(8 + k);
      dmi_read_check(addr, shadow[addr[3:0]], "DMI read after halt");
    end

    // TMS reset brings back IDCODE
    ir_scan(BYPASS1, ir_out);
    tap_reset();
    check_value(64'(tdo_oe_o), 64'd0, "tdo_oe_o in Test-Logic-Reset");
    tck_step(1'b0, 1'b0, dout[0]);
    dr_scan(32, 64'd0, dout);
    check_value(dout, 64'(IDCODE_VALUE), "IDCODE after TMS reset");

    sva_fails = u_dut.u_sva.fail_cnt;
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, sva_fails);
    if (errors == 0 && timeouts == 0 && sva_fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
src/dtm_pkg.sv
src/dtm_jtag_tap.sv
src/dtm_dmi_scan.sv
src/dmi_req_fifo.sv
src/dm_reg_bank.sv
src/dtm_top.sv
testbench/dtm_top_sva.sv
testbench/tb_dtm_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_dtm_top
FILELIST = all.f
OBJ_DIR  = obj_dir
SIM_ARGS = +verilator+error+limit+1000
LOG      = sim.log
FAIL_MSG = CHECKS FAILED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
